// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= localBusTb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= verilog.f
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) src/*.sv tb/*.sv
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then exit 1; fi
	@if ! grep -q '\*\*\* PASSED \*\*\*' $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== src/addressDecode.sv ====
`default_nettype none

module addressDecode (
  input  logic                CLK40,
  input  logic                RESETn,
  input  localBusPkg::busReqT req,
  input  logic                accept,
  input  logic                ovl,
  input  localBusPkg::configT cfg,
  output localBusPkg::targetT target,
  output logic [1:0]          ciaSelN
);

  // Transfer type qualifiers
  logic eithAccess;
  logic dataAccess;
  // Space hits
  logic z2Space;
  logic autovecHit;
  logic bridgeHit;
  logic ataSpace;
  logic regSpace;
  // Set by the first ATA write, clears only on reset
  logic ataEn;

  ////////////////////////////////////////////////////////////
  // Access type

  // Data or code in user or supervisor space, no MMU or CPU-space cycles
  assign eithAccess = (req.tm == localBusPkg::DATA_TM) || (req.tm == localBusPkg::CODE_TM);
  assign dataAccess = (req.tm == localBusPkg::DATA_TM);

  ////////////////////////////////////////////////////////////
  // Space compares

  assign z2Space = eithAccess && (req.addr[31:24] == localBusPkg::Z2_TOP);

  // Interrupt acknowledge cycles are all autovectored
  assign autovecHit = (req.tt == localBusPkg::TT_INT_ACK) &&
                      (req.addr[31:16] == localBusPkg::AUTOVEC_PAGE);

  // Bridge sits on a 256 MB window once configured
  assign bridgeHit = eithAccess && !cfg.configEnN && (req.addr[31:28] == cfg.bridgeBase);

  assign ataSpace = !cfg.configEnN && (req.addr[23:16] == cfg.ataBase);

  // Ranger and reserved ranges alias the chipset registers
  assign regSpace = (req.addr[23:20] == localBusPkg::RANGER_BLOCK) ||
                    (req.addr[23:19] == localBusPkg::RESERVED_BLOCK) ||
                    (req.addr[23:16] == localBusPkg::MOTHERBOARD_PAGE) ||
                    (req.addr[23:16] == localBusPkg::CUSTOM_PAGE);

  ////////////////////////////////////////////////////////////
  // Target priority

  always_comb begin
    target = localBusPkg::tgtNone;
    if (autovecHit) begin
      target = localBusPkg::tgtAutovector;
    end else if (bridgeHit) begin
      target = localBusPkg::tgtBridge;
    end else if (z2Space) begin
      // Overlay maps ROM over chip RAM at the reset vector
      if (ovl && (req.addr[23:19] == localBusPkg::ROM_LOW_BLOCK)) begin
        target = localBusPkg::tgtRomLow;
      end else if (!ovl && (req.addr[23:21] == localBusPkg::CHIP_RAM_BLOCK)) begin
        target = localBusPkg::tgtChipRam;
      end else if (req.addr[23:19] == localBusPkg::ROM_HIGH_BLOCK) begin
        target = localBusPkg::tgtRomHigh;
      end else if (dataAccess && (req.addr[23:16] == localBusPkg::CIA_PAGE)) begin
        target = localBusPkg::tgtCia;
      end else if (dataAccess && (req.addr[23:17] == localBusPkg::RTC_PAGE)) begin
        target = localBusPkg::tgtRtc;
      end else if (req.addr[23:16] == localBusPkg::AUTOCONFIG_PAGE) begin
        target = localBusPkg::tgtAutoConfig;
      end else if (ataSpace) begin
        // Boot driver lives in ROM until the first write
        target = ataEn ? localBusPkg::tgtAta : localBusPkg::tgtAtaRom;
      end else if (regSpace) begin
        target = localBusPkg::tgtChipReg;
      end
    end
  end

  // CIA-A on addr bit 12 low, CIA-B on addr bit 13 low
  assign ciaSelN = (target == localBusPkg::tgtCia) ? {req.addr[13], req.addr[12]} : 2'b11;

  ////////////////////////////////////////////////////////////
  // ATA mode switch

  always_ff @(posedge CLK40) begin
    if (!RESETn) begin
      ataEn <= 1'b0;
    end else if (accept && !req.rnw && (target == localBusPkg::tgtAtaRom)) begin
      ataEn <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== src/autoConfig.sv ====
`default_nettype none

module autoConfig (
  input  logic                CLK40,
  input  logic                RESETn,
  input  localBusPkg::busReqT req,
  input  logic                accept,
  input  logic                isAutoConfig,
  output localBusPkg::configT cfg
);

  // Base registers, only read once configuration is done
  logic [7:0] ataBase;
  logic [3:0] bridgeBase;
  // Configuration state
  logic       ataAssigned;
  logic       configEnN;
  // Accepted write to the base-assign register
  logic       assignWrite;

  ////////////////////////////////////////////////////////////
  // Base-assign write detect

  // Address bit 0 is not carried, the register sits on an even byte
  assign assignWrite = accept && isAutoConfig && !req.rnw &&
                       ({req.addr[7:1], 1'b0} == localBusPkg::AC_ASSIGN_OFFSET);

  // Control state
  always_ff @(posedge CLK40) begin
    if (!RESETn) begin
      ataAssigned <= 1'b0;
      configEnN   <= 1'b1;
    end else if (assignWrite && configEnN) begin
      if (!ataAssigned) begin
        ataAssigned <= 1'b1;
      end else begin
        // Second write closes the chain
        configEnN <= 1'b0;
      end
    end
  end

  // Base payload, first write is ATA, second is bridge
  always_ff @(posedge CLK40) begin
    if (assignWrite && configEnN) begin
      if (!ataAssigned) begin
        ataBase <= req.wdata;
      end else begin
        bridgeBase <= req.wdata[7:4];
      end
    end
  end

  assign cfg = '{ataBase: ataBase, bridgeBase: bridgeBase, configEnN: configEnN};

endmodule

`default_nettype wire

// ==== src/busArbiter.sv ====
`default_nettype none

module busArbiter (
  input  logic                CLK40,
  input  logic                RESETn,
  input  localBusPkg::busReqT cpuReq,
  input  logic                cpuValid,
  output logic                cpuReady,
  input  localBusPkg::busReqT dmaReq,
  input  logic                dmaValid,
  output logic                dmaReady,
  output localBusPkg::busReqT grantReq,
  output logic                grantValid,
  output logic                grantMaster,
  input  logic                grantReady
);

  // Master that won the last accepted grant, 0 CPU and 1 DMA
  logic lastWinner;
  // Current pick, high when DMA owns the bus this cycle
  logic pickDma;
  // Grant taken by the cycle stage
  logic grantTaken;

  ////////////////////////////////////////////////////////////
  // Round-robin pick

  // DMA wins when alone, or when both ask and the CPU had the last turn
  assign pickDma = dmaValid && (!cpuValid || !lastWinner);

  assign grantValid  = cpuValid || dmaValid;
  assign grantMaster = pickDma;

  // Winner's payload goes to the cycle stage
  assign grantReq = pickDma ? dmaReq : cpuReq;

  // Ready follows the cycle stage but is withheld from the loser
  // An idle bus shows ready to both masters
  assign cpuReady = grantReady && !pickDma;
  assign dmaReady = grantReady && !(cpuValid && !pickDma);

  assign grantTaken = grantValid && grantReady;

  ////////////////////////////////////////////////////////////
  // Last-winner state

  // Reset marks DMA as last winner so the CPU goes first
  always_ff @(posedge CLK40) begin
    if (!RESETn) begin
      lastWinner <= 1'b1;
    end else if (grantTaken) begin
      // Only an accepted grant moves the turn
      lastWinner <= pickDma;
    end
  end

endmodule

`default_nettype wire

// ==== src/busCycle.sv ====
`default_nettype none

module busCycle (
  input  logic                 CLK40,
  input  logic                 RESETn,
  input  localBusPkg::busReqT  grantReq,
  input  logic                 grantValid,
  input  logic                 grantMaster,
  output logic                 grantReady,
  input  localBusPkg::targetT  target,
  input  logic [1:0]           ciaSelN,
  output logic                 accept,
  output localBusPkg::busRespT resp,
  output logic                 respValid,
  input  logic                 respReady
);

  // Result built from the current decode
  localBusPkg::busRespT nextResp;

  ////////////////////////////////////////////////////////////
  // Handshake

  // Free when empty, or when the held result leaves this cycle
  assign grantReady = !respValid || respReady;

  // One-cycle pulse, also strobes decoder and autoconfig state
  assign accept = grantValid && grantReady;

  ////////////////////////////////////////////////////////////
  // Result register

  always_comb begin
    nextResp.target   = target;
    nextResp.ciaSelN  = ciaSelN;
    nextResp.master   = grantMaster;
    nextResp.wasWrite = !grantReq.rnw;
  end

  // Valid flag
  always_ff @(posedge CLK40) begin
    if (!RESETn) begin
      respValid <= 1'b0;
    end else if (accept) begin
      respValid <= 1'b1;
    end else if (respReady) begin
      respValid <= 1'b0;
    end
  end

  // Payload, loads only on accept and holds under back-pressure
  always_ff @(posedge CLK40) begin
    if (accept) begin
      resp <= nextResp;
    end
  end

endmodule

`default_nettype wire

// ==== src/localBusPkg.sv ====
`default_nettype none

package localBusPkg;

  ////////////////////////////////////////////////////////////
  // Address map constants

  // Zorro II space is the bottom 16 MB
  localparam logic [7:0]  Z2_TOP           = 8'h00;

  // ROM and chip RAM blocks
  localparam logic [4:0]  ROM_LOW_BLOCK    = 5'b00000;  // addr[23:19], 512 KB at 0
  localparam logic [4:0]  ROM_HIGH_BLOCK   = 5'b11111;  // addr[23:19], F8 to FF
  localparam logic [2:0]  CHIP_RAM_BLOCK   = 3'b000;    // addr[23:21], 2 MB at 0

  // Peripheral pages
  localparam logic [7:0]  CIA_PAGE         = 8'hBF;     // addr[23:16]
  localparam logic [6:0]  RTC_PAGE         = 7'h6E;     // addr[23:17], DC to DD
  localparam logic [7:0]  AUTOCONFIG_PAGE  = 8'hE8;     // addr[23:16]

  // Chipset register spaces
  localparam logic [3:0]  RANGER_BLOCK     = 4'hC;      // addr[23:20], C0 to CF
  localparam logic [4:0]  RESERVED_BLOCK   = 5'b11010;  // addr[23:19], D0 to D7
  localparam logic [7:0]  MOTHERBOARD_PAGE = 8'hDE;
  localparam logic [7:0]  CUSTOM_PAGE      = 8'hDF;

  // Interrupt acknowledge lands in FFFF xxxx
  localparam logic [15:0] AUTOVEC_PAGE     = 16'hFFFF;
  localparam logic [1:0]  TT_INT_ACK       = 2'b11;

  // Transfer modifier patterns for user or supervisor accesses
  localparam logic [1:0]  DATA_TM          = 2'b01;
  localparam logic [1:0]  CODE_TM          = 2'b10;

  // Base-assign register in the autoconfig page
  localparam logic [7:0]  AC_ASSIGN_OFFSET = 8'h48;

  ////////////////////////////////////////////////////////////
  // Bus types

  // One local bus cycle as presented by a master
  typedef struct packed {
    logic [31:1] addr;
    logic        rnw;
    logic [1:0]  tt;
    logic [1:0]  tm;
    logic [7:0]  wdata;
  } busReqT;

  // Decoded target, one code per space
  typedef enum logic [3:0] {
    tgtNone       = 4'd0,
    tgtRomLow     = 4'd1,
    tgtRomHigh    = 4'd2,
    tgtChipRam    = 4'd3,
    tgtChipReg    = 4'd4,
    tgtCia        = 4'd5,
    tgtRtc        = 4'd6,
    tgtAutoConfig = 4'd7,
    tgtAtaRom     = 4'd8,
    tgtAta        = 4'd9,
    tgtBridge     = 4'd10,
    tgtAutovector = 4'd11
  } targetT;

  // Result handed back to the requester
  typedef struct packed {
    targetT     target;
    logic [1:0] ciaSelN;    // bit 0 CIA-A, bit 1 CIA-B, active low
    logic       master;     // 0 CPU, 1 DMA
    logic       wasWrite;
  } busRespT;

  // Autoconfig state seen by the decoder
  typedef struct packed {
    logic [7:0] ataBase;
    logic [3:0] bridgeBase;
    logic       configEnN;
  } configT;

endpackage

`default_nettype wire

// ==== src/localBusTop.sv ====
`default_nettype none

module localBusTop (
  input  logic                 CLK40,
  input  logic                 RESETn,
  // CPU requester
  input  localBusPkg::busReqT  cpuReq,
  input  logic                 cpuValid,
  output logic                 cpuReady,
  // DMA requester
  input  localBusPkg::busReqT  dmaReq,
  input  logic                 dmaValid,
  output logic                 dmaReady,
  // Decode result
  output localBusPkg::busRespT resp,
  output logic                 respValid,
  input  logic                 respReady,
  // Boot overlay level
  input  logic                 ovl,
  output logic                 configDone
);

  // Granted cycle
  localBusPkg::busReqT grantReq;
  logic                grantValid;
  logic                grantMaster;
  logic                grantReady;
  logic                accept;
  // Decode and configuration
  localBusPkg::targetT target;
  logic [1:0]          ciaSelN;
  localBusPkg::configT cfg;
  logic                isAutoConfig;

  ////////////////////////////////////////////////////////////
  // Arbiter and cycle stage

  busArbiter u_busArbiter (
    .CLK40(CLK40), .RESETn(RESETn),
    .cpuReq(cpuReq), .cpuValid(cpuValid), .cpuReady(cpuReady),
    .dmaReq(dmaReq), .dmaValid(dmaValid), .dmaReady(dmaReady),
    .grantReq(grantReq), .grantValid(grantValid), .grantMaster(grantMaster),
    .grantReady(grantReady)
  );

  busCycle u_busCycle (
    .CLK40(CLK40), .RESETn(RESETn),
    .grantReq(grantReq), .grantValid(grantValid), .grantMaster(grantMaster),
    .grantReady(grantReady), .target(target), .ciaSelN(ciaSelN),
    .accept(accept), .resp(resp), .respValid(respValid), .respReady(respReady)
  );

  ////////////////////////////////////////////////////////////
  // Decoder and autoconfig

  addressDecode u_addressDecode (
    .CLK40(CLK40), .RESETn(RESETn), .req(grantReq), .accept(accept),
    .ovl(ovl), .cfg(cfg), .target(target), .ciaSelN(ciaSelN)
  );

  assign isAutoConfig = (target == localBusPkg::tgtAutoConfig);

  autoConfig u_autoConfig (
    .CLK40(CLK40), .RESETn(RESETn), .req(grantReq), .accept(accept),
    .isAutoConfig(isAutoConfig), .cfg(cfg)
  );

  assign configDone = !cfg.configEnN;

endmodule

`default_nettype wire

// ==== tb/decodeCases.txt ====
# par master addr rnw tt tm wdata ovl target ciaSelN  (all hex)
# par 1 presents this line and the next one together
0 0 00000100 1 0 1 00 1 1 3
0 0 00000100 1 0 2 00 0 3 3
0 0 00F80000 1 0 2 00 0 2 3
0 1 00FFFFF0 1 0 1 00 0 2 3
0 0 00BFE001 1 0 1 00 0 5 2
0 0 00BFD000 0 0 1 5A 0 5 1
0 0 00BFE001 1 0 2 00 0 0 3
0 1 00DC0000 1 0 1 00 0 6 3
0 0 00DC0000 1 0 2 00 0 0 3
0 0 FFFFFFF8 1 3 0 00 0 B 3
0 0 00200000 1 0 1 00 0 0 3
0 0 40000000 1 0 1 00 0 0 3
0 0 00E80048 0 0 1 20 0 7 3
0 0 00E80048 0 0 1 40 0 7 3
0 0 40000010 1 0 1 00 0 A 3
0 1 00200000 1 0 1 00 0 8 3
0 0 00200000 0 0 1 33 0 8 3
0 0 00200004 1 0 1 00 0 9 3
0 0 00DFF000 1 0 1 00 0 4 3
0 1 00C00000 0 0 1 11 0 4 3
1 0 00F80000 1 0 2 00 0 2 3
0 1 00000200 1 0 1 00 0 3 3
1 1 00200008 0 0 1 44 0 9 3
0 0 00DE0000 1 0 1 00 0 4 3

// ==== tb/localBusChecker.sv ====
`default_nettype none

module localBusChecker (
  input  logic                 CLK40,
  input  logic                 RESETn,
  input  localBusPkg::busRespT resp,
  input  logic                 respValid,
  input  logic                 respReady
);
  timeunit 1ns;
  timeprecision 100ps;

  // Expected results in response order
  localBusPkg::busRespT expQ[$];
  int passCount = 0;
  int failCount = 0;
  int respCount = 0;

  task automatic pushExpected(input localBusPkg::busRespT e);
    expQ.push_back(e);
  endtask

  ////////////////////////////////////////////////////////////
  // Compare on every response handshake

  always @(posedge CLK40) begin
    localBusPkg::busRespT e;
    logic bad;
    string verdict;
    if (RESETn && respValid && respReady) begin
      respCount = respCount + 1;
      if (expQ.size() == 0) begin
        $display("Response %0d arrived with nothing expected", respCount);
        failCount = failCount + 1;
      end else begin
        e = expQ.pop_front();
        bad = 1'b0;
        if (resp.target != e.target) begin
          $display("Error at %0t: resp.target = %0d, expected %0d", $time,
                   resp.target, e.target);
          bad = 1'b1;
        end
        if (resp.ciaSelN != e.ciaSelN) begin
          $display("Error at %0t: resp.ciaSelN = %b, expected %b", $time,
                   resp.ciaSelN, e.ciaSelN);
          bad = 1'b1;
        end
        if (resp.master != e.master) begin
          $display("Error at %0t: resp.master = %0d, expected %0d", $time,
                   resp.master, e.master);
          bad = 1'b1;
        end
        if (resp.wasWrite != e.wasWrite) begin
          $display("Error at %0t: resp.wasWrite = %0d, expected %0d", $time,
                   resp.wasWrite, e.wasWrite);
          bad = 1'b1;
        end
        if (bad) begin
          failCount = failCount + 1;
          verdict = "mismatch";
        end else begin
          passCount = passCount + 1;
          verdict = "ok";
        end
        $display("Test %0d master %0d target %0d: %s", respCount, resp.master,
                 resp.target, verdict);
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb/localBusTb.sv ====
`default_nettype none

module localBusTb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int MAX_CASES = 64;

  // Clock and reset
  logic CLK40;
  logic RESETn;
  // DUT ports
  localBusPkg::busReqT  cpuReq;
  logic                 cpuValid;
  logic                 cpuReady;
  localBusPkg::busReqT  dmaReq;
  logic                 dmaValid;
  logic                 dmaReady;
  localBusPkg::busRespT resp;
  logic                 respValid;
  logic                 respReady;
  logic                 ovl;
  logic                 configDone;

  // Case table, one entry per line of the case file
  logic        cPar[MAX_CASES];
  logic        cMaster[MAX_CASES];
  logic [31:0] cAddr[MAX_CASES];
  logic        cRnw[MAX_CASES];
  logic [1:0]  cTt[MAX_CASES];
  logic [1:0]  cTm[MAX_CASES];
  logic [7:0]  cWdata[MAX_CASES];
  logic        cOvl[MAX_CASES];
  logic [3:0]  cTarget[MAX_CASES];
  logic [1:0]  cCiaSelN[MAX_CASES];
  int          numCases;

  // Driver state
  logic cpuPend;
  logic dmaPend;
  logic lastMaster;     // Round-robin model, 0 CPU and 1 DMA
  int   seed;
  int   cycleCount = 0;
  int   cycleLimit;
  int   extraFails;

  localBusTop u_localBusTop (
    .CLK40(CLK40), .RESETn(RESETn),
    .cpuReq(cpuReq), .cpuValid(cpuValid), .cpuReady(cpuReady),
    .dmaReq(dmaReq), .dmaValid(dmaValid), .dmaReady(dmaReady),
    .resp(resp), .respValid(respValid), .respReady(respReady),
    .ovl(ovl), .configDone(configDone)
  );

  localBusChecker u_checker (
    .CLK40(CLK40), .RESETn(RESETn),
    .resp(resp), .respValid(respValid), .respReady(respReady)
  );

  ////////////////////////////////////////////////////////////
  // Clock, stalls and watchdog

  initial begin
    CLK40 = 1'b0;
    forever #10 CLK40 = ~CLK40;
  end

  // About one stall in four on the response port
  initial begin
    respReady = 1'b1;
    seed = 55797;
    forever begin
      @(negedge CLK40);
      respReady = (($random(seed) % 4) != 0);
    end
  end

  always @(posedge CLK40) begin
    cycleCount = cycleCount + 1;
    if (cycleLimit > 0 && cycleCount > cycleLimit) begin
      $display("Timeout after %0d cycles, responses still missing", cycleCount);
      endRun(1'b0);
    end
  end

  ////////////////////////////////////////////////////////////
  // Case file

  task automatic readCases();
    int        fd;
    int        n;
    string     line;
    logic [3:0] par;
    logic [3:0] mst;
    logic [3:0] rnw;
    logic [3:0] ov;
    numCases = 0;
    fd = $fopen("tb/decodeCases.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the case file tb/decodeCases.txt");
      extraFails = extraFails + 1;
    end else begin
      while (!$feof(fd) && numCases < MAX_CASES) begin
        line = "";
        n = $fgets(line, fd);
        // Skip comments and blank lines
        if (line.len() < 4 || line.substr(0, 0) == "#") begin
          continue;
        end
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", par, mst, cAddr[numCases],
                    rnw, cTt[numCases], cTm[numCases], cWdata[numCases], ov,
                    cTarget[numCases], cCiaSelN[numCases]);
        if (n == 10) begin
          cPar[numCases]    = par[0];
          cMaster[numCases] = mst[0];
          cRnw[numCases]    = rnw[0];
          cOvl[numCases]    = ov[0];
          numCases = numCases + 1;
        end
      end
      $fclose(fd);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus

  // Expected result for one case
  function automatic localBusPkg::busRespT expectedOf(input int i);
    localBusPkg::busRespT e;
    e.target   = localBusPkg::targetT'(cTarget[i]);
    e.ciaSelN  = cCiaSelN[i];
    e.master   = cMaster[i];
    e.wasWrite = !cRnw[i];
    return e;
  endfunction

  // Put one case on its master's port
  task automatic loadSlot(input int i);
    localBusPkg::busReqT r;
    r.addr  = cAddr[i][31:1];
    r.rnw   = cRnw[i];
    r.tt    = cTt[i];
    r.tm    = cTm[i];
    r.wdata = cWdata[i];
    if (cMaster[i]) begin
      dmaReq  = r;
      dmaPend = 1'b1;
    end else begin
      cpuReq  = r;
      cpuPend = 1'b1;
    end
  endtask

  // Present one case, or a pair from both masters at once
  task automatic issueCases(input int first, input logic pair);
    logic loaded;
    logic takeCpu;
    logic takeDma;
    int   winner;
    loaded = 1'b0;
    while (!loaded || cpuPend || dmaPend) begin
      @(negedge CLK40);
      if (!loaded) begin
        loaded = 1'b1;
        ovl = cOvl[first];
        loadSlot(first);
        if (pair) begin
          loadSlot(first + 1);
          // Both valid, the master that did not win last goes first
          winner = (cMaster[first] != lastMaster) ? first : first + 1;
          u_checker.pushExpected(expectedOf(winner));
          u_checker.pushExpected(expectedOf(winner == first ? first + 1 : first));
          lastMaster = cMaster[winner == first ? first + 1 : first];
        end else begin
          u_checker.pushExpected(expectedOf(first));
          lastMaster = cMaster[first];
        end
      end
      cpuValid = cpuPend;
      dmaValid = dmaPend;
      #1;
      takeCpu = cpuValid && cpuReady;
      takeDma = dmaValid && dmaReady;
      @(posedge CLK40);
      if (takeCpu) cpuPend = 1'b0;
      if (takeDma) dmaPend = 1'b0;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Run end

  task automatic endRun(input logic ok);
    $display("Done: %0d passed, %0d failed", u_checker.passCount,
             u_checker.failCount + extraFails);
    if (ok) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  endtask

  initial begin
    int i;
    RESETn     = 1'b0;
    cpuReq     = '0;
    cpuValid   = 1'b0;
    dmaReq     = '0;
    dmaValid   = 1'b0;
    ovl        = 1'b1;
    cpuPend    = 1'b0;
    dmaPend    = 1'b0;
    lastMaster = 1'b1;
    cycleLimit = 0;
    extraFails = 0;
    readCases();
    cycleLimit = numCases * 8 + 50;
    repeat (5) @(posedge CLK40);
    @(negedge CLK40);
    RESETn = 1'b1;
    if (configDone) begin
      $display("configDone is high straight after reset");
      extraFails = extraFails + 1;
    end
    if (!cpuReady || !dmaReady) begin
      $display("Request ready is low straight after reset");
      extraFails = extraFails + 1;
    end
    i = 0;
    while (i < numCases) begin
      if (cPar[i] && i + 1 < numCases) begin
        issueCases(i, 1'b1);
        i = i + 2;
      end else begin
        issueCases(i, 1'b0);
        i = i + 1;
      end
    end
    @(negedge CLK40);
    cpuValid = 1'b0;
    dmaValid = 1'b0;
    // Let the last responses drain
    while (u_checker.respCount < numCases) @(posedge CLK40);
    repeat (3) @(posedge CLK40);
    if (u_checker.respCount != numCases) begin
      $display("Got %0d responses for %0d cases", u_checker.respCount, numCases);
      extraFails = extraFails + 1;
    end
    if (!configDone) begin
      $display("configDone never went high after the two assign writes");
      extraFails = extraFails + 1;
    end
    endRun(u_checker.failCount == 0 && extraFails == 0);
  end

endmodule

`default_nettype wire

// ==== tb/localBus_props.sv ====
`default_nettype none

module localBus_props (
  input logic                 CLK40,
  input logic                 RESETn,
  input localBusPkg::busRespT resp,
  input logic                 respValid,
  input logic                 respReady,
  input logic                 accept
);
  timeunit 1ns;
  timeprecision 100ps;

  // Register empties under reset
  resetEmpty: assert property (@(posedge CLK40) !RESETn |=> !respValid)
    else $error("respValid high during reset");

  // Held result under back-pressure
  holdStable: assert property (@(posedge CLK40) disable iff (!RESETn)
    respValid && !respReady |=> respValid && $stable(resp))
    else $error("resp changed while stalled");

  // Accepted cycle is presented on the next edge
  acceptToValid: assert property (@(posedge CLK40) disable iff (!RESETn)
    accept |=> respValid)
    else $error("respValid missing one cycle after accept");

endmodule

bind busCycle localBus_props u_localBusProps (
  .CLK40(CLK40), .RESETn(RESETn), .resp(resp), .respValid(respValid),
  .respReady(respReady), .accept(accept)
);

`default_nettype wire

// ==== verilog.f ====
src/localBusPkg.sv
src/busArbiter.sv
src/addressDecode.sv
src/autoConfig.sv
src/busCycle.sv
src/localBusTop.sv
tb/localBusChecker.sv
tb/localBus_props.sv
tb/localBusTb.sv
